// ==== du_cpu_top.f ====
+incdir+include
hw/du_cpu_pkg.sv
hw/uart_core.sv
hw/debug_unit.sv
hw/data_path.sv
hw/du_cpu_top.sv
dv/du_cpu_tb.sv

// ==== dv/du_cpu_tb.sv ====
`timescale 1ns/1ns
`include "du_cpu_params.svh"

module du_cpu_tb import du_cpu_pkg::*; ();

    localparam int NROWS      = 4;
    localparam int MAX_INSN   = 8;
    localparam int MAX_CMD    = 8;
    localparam int DUMP_WORDS = 1 + `DU_NUM_REGS + `DU_DM_DEPTH;
    localparam int CPB        = `DU_CLKS_PER_BIT;

    logic       i_clock = 1'b0;
    logic       i_arst_n;
    logic       i_uart_rx;
    logic       o_uart_tx;
    logic       o_hlt;
    logic [3:0] o_state;

    // Stimulus table, expected dumps filled in by the model
    insn_t       prog     [NROWS][MAX_INSN];
    int          prog_len [NROWS];
    du_cmd_e     cmd      [NROWS];
    int          n_cmd    [NROWS];
    logic [7:0]  junk     [NROWS]; // Unknown command byte, zero for none
    logic [31:0] exp_dump [NROWS][MAX_CMD][DUMP_WORDS];
    logic        exp_hlt  [NROWS][MAX_CMD];

    // Reference machine state
    insn_t       m_imem [`DU_IM_DEPTH];
    logic [31:0] m_regs [`DU_NUM_REGS];
    logic [31:0] m_dm   [`DU_DM_DEPTH];
    int          m_pc;
    logic        m_halt;

    logic [7:0]  tx_q [$];
    logic [31:0] rng = 32'hc862;
    int          total_bytes = 0;
    int          timeout_limit = 0;
    int          cycle_cnt = 0;

    du_cpu_top i_dut (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_hlt     (o_hlt),
        .o_state   (o_state)
    );

    always #2 i_clock = ~i_clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    always @(posedge i_clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit)
            abort_run($sformatf("Timeout, the test did not end within %0d cycles", cycle_cnt));
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%02h expected 0x%02h",
                                $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
    endtask

    task automatic check_state(input string name, input logic [3:0] got, input du_state_e exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %0d expected %0d (%s)",
                                $time, name, got, exp, exp.name()));
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [IMM_W-1:0] rand_imm();
        logic [31:0] r;
        r = next_rand();
        return r[IMM_W-1:0];
    endfunction

    function automatic insn_t enc_r(input opcode_e op, input int rd, input int rs, input int rt);
        insn_t w;
        w = '0;
        w.r.opcode = op;
        w.r.rd = rd[REG_AW-1:0];
        w.r.rs = rs[REG_AW-1:0];
        w.r.rt = rt[REG_AW-1:0];
        return w;
    endfunction

    function automatic insn_t enc_i(input opcode_e op, input int rd, input int rs,
                                    input logic [IMM_W-1:0] imm);
        insn_t w;
        w = '0;
        w.i.opcode = op;
        w.i.rd = rd[REG_AW-1:0];
        w.i.rs = rs[REG_AW-1:0];
        w.i.imm = imm;
        return w;
    endfunction

    task automatic add_insn(input int row, input insn_t w);
        prog[row][prog_len[row]] = w;
        prog_len[row]++;
    endtask

    // One instruction of the reference machine
    function automatic void model_exec();
        insn_t       w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        int          simm;
        int          di;
        if (m_halt) return;
        w = m_imem[m_pc];
        a = m_regs[w.r.rs];
        b = m_regs[w.r.rt];
        simm = w.i.imm; // Sign extends
        ea = a + 32'(simm);
        di = int'(ea % `DU_DM_DEPTH);
        case (w.r.opcode)
            OP_ADD:  if (w.r.rd != 0) m_regs[w.r.rd] = a + b;
            OP_SUB:  if (w.r.rd != 0) m_regs[w.r.rd] = a - b;
            OP_ADDI: if (w.r.rd != 0) m_regs[w.r.rd] = ea;
            OP_LW:   if (w.r.rd != 0) m_regs[w.r.rd] = m_dm[di];
            OP_SW:   m_dm[di] = m_regs[w.r.rd];
            OP_HALT: m_halt = 1'b1;
            default: ;
        endcase
        if (!m_halt) m_pc = (m_pc + 1) % `DU_IM_DEPTH;
    endfunction

    task automatic build_table();
        for (int r = 0; r < NROWS; r++) begin
            prog_len[r] = 0;
            n_cmd[r] = 1;
            cmd[r] = CMD_RUN;
            junk[r] = 8'h00;
        end
        // Arithmetic, ends with a write to r0
        add_insn(0, enc_i(OP_ADDI, 1, 0, rand_imm()));
        add_insn(0, enc_i(OP_ADDI, 2, 0, rand_imm()));
        add_insn(0, enc_r(OP_ADD, 3, 1, 2));
        add_insn(0, enc_r(OP_SUB, 4, 1, 2));
        add_insn(0, enc_i(OP_ADDI, 5, 3, rand_imm()));
        add_insn(0, enc_r(OP_SUB, 6, 2, 1));
        add_insn(0, enc_r(OP_ADD, 0, 1, 2));
        add_insn(0, enc_r(OP_HALT, 0, 0, 0));
        // Loads and stores, offsets far past the data depth
        add_insn(1, enc_i(OP_ADDI, 7, 0, rand_imm()));
        add_insn(1, enc_i(OP_SW, 1, 2, rand_imm()));
        add_insn(1, enc_i(OP_SW, 7, 1, rand_imm()));
        add_insn(1, enc_i(OP_SW, 3, 7, rand_imm()));
        add_insn(1, enc_i(OP_LW, 6, 1, rand_imm()));
        add_insn(1, enc_i(OP_LW, 0, 2, rand_imm()));
        add_insn(1, enc_i(OP_ADDI, 0, 7, rand_imm()));
        add_insn(1, enc_r(OP_HALT, 0, 0, 0));
        // Single steps, the last one after HALT
        add_insn(2, enc_r(OP_NOP, 0, 0, 0));
        add_insn(2, enc_i(OP_ADDI, 7, 7, rand_imm()));
        add_insn(2, enc_r(OP_ADD, 6, 7, 5));
        add_insn(2, enc_i(OP_SW, 6, 0, rand_imm()));
        add_insn(2, enc_r(OP_HALT, 0, 0, 0));
        cmd[2] = CMD_STEP;
        n_cmd[2] = 6;
        // Reload after halt, unknown byte first
        add_insn(3, enc_r(OP_SUB, 2, 3, 1));
        add_insn(3, enc_i(OP_LW, 1, 7, rand_imm()));
        add_insn(3, enc_i(OP_SW, 2, 1, rand_imm()));
        add_insn(3, enc_r(OP_HALT, 0, 0, 0));
        junk[3] = 8'h3F;
    endtask

    task automatic fill_expected();
        for (int i = 0; i < `DU_NUM_REGS; i++)
            m_regs[i] = '0;
        for (int i = 0; i < `DU_DM_DEPTH; i++)
            m_dm[i] = '0;
        for (int r = 0; r < NROWS; r++) begin
            for (int k = 0; k < prog_len[r]; k++)
                m_imem[k] = prog[r][k];
            m_pc = 0;
            m_halt = 1'b0;
            total_bytes += 3 + 4 * prog_len[r] + ((junk[r] != 8'h00) ? 1 : 0);
            total_bytes += n_cmd[r] * (1 + 4 * DUMP_WORDS);
            for (int c = 0; c < n_cmd[r]; c++) begin
                if (cmd[r] == CMD_RUN) begin
                    for (int g = 0; g < 64 && !m_halt; g++)
                        model_exec();
                end else begin
                    model_exec();
                end
                exp_dump[r][c][0] = 32'(m_pc);
                for (int i = 0; i < `DU_NUM_REGS; i++)
                    exp_dump[r][c][1 + i] = m_regs[i];
                for (int i = 0; i < `DU_DM_DEPTH; i++)
                    exp_dump[r][c][1 + `DU_NUM_REGS + i] = m_dm[i];
                exp_hlt[r][c] = m_halt;
            end
        end
    endtask

    // Host side serial transmit, 8N1 LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clock);
            i_uart_rx <= frame[i];
            repeat (CPB - 1) @(posedge i_clock);
        end
    endtask

    task automatic get_tx_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        while (tx_q.size() == 0) begin
            @(posedge i_clock);
            waited++;
            if (waited > 40 * CPB) abort_run("No reply byte from the DUT on o_uart_tx");
        end
        b = tx_q.pop_front();
    endtask

    function automatic string dump_name(input int r, input int c, input int i);
        if (i == 0) return $sformatf("row %0d cmd %0d dump pc", r, c);
        if (i <= `DU_NUM_REGS) return $sformatf("row %0d cmd %0d dump reg[%0d]", r, c, i - 1);
        return $sformatf("row %0d cmd %0d dump dm[%0d]", r, c, i - 1 - `DU_NUM_REGS);
    endfunction

    task automatic apply_row(input int r);
        logic [7:0]  b;
        logic [31:0] word;
        send_byte(CMD_LOAD);
        send_byte(8'(prog_len[r]));
        for (int k = 0; k < prog_len[r]; k++) begin
            word = prog[r][k];
            for (int j = 0; j < 4; j++)
                send_byte(word[8*j +: 8]);
        end
        get_tx_byte(b);
        check_byte($sformatf("row %0d load reply", r), b, `DU_ACK_BYTE);
        check_byte("o_hlt after load", {7'b0, o_hlt}, 8'h00);
        if (junk[r] != 8'h00) begin
            send_byte(junk[r]);
            repeat (20 * CPB) @(posedge i_clock);
            if (tx_q.size() != 0) abort_run("The DUT replied to an unknown command byte");
            check_state("o_state after unknown byte", o_state, IDLE);
        end
        for (int c = 0; c < n_cmd[r]; c++) begin
            send_byte(cmd[r]);
            for (int i = 0; i < DUMP_WORDS; i++) begin
                for (int j = 0; j < 4; j++) begin
                    get_tx_byte(b);
                    word[8*j +: 8] = b; // Little-endian
                end
                check_word(dump_name(r, c, i), word, exp_dump[r][c][i]);
            end
            check_byte("o_hlt after dump", {7'b0, o_hlt}, {7'b0, exp_hlt[r][c]});
            check_state("o_state after dump", o_state, IDLE);
        end
    endtask

    // Decodes o_uart_tx, sampling mid-bit
    initial begin : tx_monitor
        logic [7:0] rx_byte;
        wait (i_arst_n === 1'b1);
        forever begin
            @(posedge i_clock);
            if (o_uart_tx === 1'b0) begin
                repeat (CPB / 2) @(posedge i_clock);
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(posedge i_clock);
                    rx_byte[i] = o_uart_tx;
                end
                repeat (CPB) @(posedge i_clock);
                if (o_uart_tx !== 1'b1) abort_run("Framing error, stop bit low on o_uart_tx");
                tx_q.push_back(rx_byte);
            end
        end
    end

    initial begin
        i_arst_n = 1'b0;
        i_uart_rx = 1'b1;
        build_table();
        fill_expected();
        timeout_limit = total_bytes * 10 * CPB * 2;
        repeat (4) @(posedge i_clock);
        i_arst_n <= 1'b1;
        @(posedge i_clock);
        check_byte("o_hlt after reset", {7'b0, o_hlt}, 8'h00);
        check_state("o_state after reset", o_state, IDLE);
        for (int r = 0; r < NROWS; r++)
            apply_row(r);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== hw/data_path.sv ====
`timescale 1ns/1ns
`include "du_cpu_params.svh"

module data_path import du_cpu_pkg::*; (
    input  logic        i_clock,
    input  logic        i_arst_n,
    input  dbg_access_t i_dbg,
    input  logic        i_pc_clear,
    output logic [31:0] o_pc,
    output logic [31:0] o_reg_data,
    output logic [31:0] o_dm_data,
    output logic        o_hlt
);

    insn_t            imem [`DU_IM_DEPTH];
    logic [31:0]      regs [`DU_NUM_REGS];
    logic [31:0]      dmem [`DU_DM_DEPTH];

    logic [IM_AW-1:0] pc;
    insn_t            insn;
    logic             exec;
    logic [31:0]      rs_val;
    logic [31:0]      rt_val;
    logic [31:0]      rd_val;
    logic [31:0]      simm;
    logic [31:0]      ea;
    logic [DM_AW-1:0] dm_idx;
    logic             rf_we;
    logic [31:0]      rf_wdata;
    logic             dm_we;
    logic             halt_now;

    function automatic logic [31:0] rf_read(input logic [REG_AW-1:0] idx);
        return (idx == '0) ? 32'd0 : regs[idx];
    endfunction

    assign insn   = imem[pc];
    assign exec   = i_dbg.exec_en && !o_hlt;
    assign rs_val = rf_read(insn.r.rs);
    assign rt_val = rf_read(insn.r.rt);
    assign rd_val = rf_read(insn.r.rd);
    assign simm   = {{(32-IMM_W){insn.i.imm[IMM_W-1]}}, insn.i.imm};
    assign ea     = rs_val + simm;
    assign dm_idx = ea[DM_AW-1:0]; // Wraps over the data memory

    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = '0;
        dm_we    = 1'b0;
        halt_now = 1'b0;
        case (insn.r.opcode)
            OP_ADD: begin
                rf_we    = 1'b1;
                rf_wdata = rs_val + rt_val;
            end
            OP_SUB: begin
                rf_we    = 1'b1;
                rf_wdata = rs_val - rt_val;
            end
            OP_ADDI: begin
                rf_we    = 1'b1;
                rf_wdata = ea;
            end
            OP_LW: begin
                rf_we    = 1'b1;
                rf_wdata = dmem[dm_idx];
            end
            OP_SW:   dm_we = 1'b1;
            OP_HALT: halt_now = 1'b1;
            OP_NOP:  ;
            default: ; // Undefined opcodes act as NOP
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_dbg.im_we) imem[i_dbg.im_addr] <= i_dbg.im_wdata;
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `DU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exec && rf_we && insn.r.rd != '0) begin
            regs[insn.r.rd] <= rf_wdata;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `DU_DM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (exec && dm_we) begin
            dmem[dm_idx] <= rd_val;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc    <= '0;
            o_hlt <= 1'b0;
        end else if (i_pc_clear) begin
            pc    <= '0;
            o_hlt <= 1'b0;
        end else if (exec) begin
            if (halt_now) o_hlt <= 1'b1; // pc stays on the HALT
            else pc <= pc + 1'b1;
        end
    end

    // Debug reads of the current state
    assign o_pc       = 32'(pc);
    assign o_reg_data = rf_read(i_dbg.rd_addr[REG_AW-1:0]);
    assign o_dm_data  = dmem[i_dbg.rd_addr[DM_AW-1:0]];

endmodule

// ==== hw/debug_unit.sv ====
`timescale 1ns/1ns
`include "du_cpu_params.svh"

module debug_unit import du_cpu_pkg::*; (
    input  logic        i_clock,
    input  logic        i_arst_n,
    input  logic [7:0]  i_rx_data,
    input  logic        i_rx_done,
    input  logic        i_tx_done,
    input  logic [31:0] i_pc,
    input  logic [31:0] i_reg_data,
    input  logic [31:0] i_dm_data,
    input  logic        i_hlt,
    output logic [7:0]  o_tx_data,
    output logic        o_tx_start,
    output dbg_access_t o_dbg,
    output logic        o_pc_clear,
    output logic [3:0]  o_state
);

    du_state_e        state;
    logic [7:0]       word_cnt;
    logic [7:0]       word_idx;
    logic [1:0]       byte_idx;
    logic [31:0]      insn_buf;
    logic             im_we;
    logic [IM_AW-1:0] im_addr;
    logic             tx_busy;
    logic [31:0]      dump_word;
    logic             last_word;

    always_comb begin
        case (state)
            DUMP_PC:  dump_word = i_pc;
            DUMP_REG: dump_word = i_reg_data;
            default:  dump_word = i_dm_data;
        endcase
    end

    assign last_word = (state == DUMP_REG) ? (word_idx == 8'(`DU_NUM_REGS - 1))
                                           : (word_idx == 8'(`DU_DM_DEPTH - 1));

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= IDLE;
            word_cnt   <= '0;
            word_idx   <= '0;
            byte_idx   <= '0;
            im_we      <= 1'b0;
            im_addr    <= '0;
            tx_busy    <= 1'b0;
            o_tx_start <= 1'b0;
            o_tx_data  <= '0;
        end else begin
            im_we      <= 1'b0;
            o_tx_start <= 1'b0;
            if (i_tx_done) tx_busy <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: state <= LOAD_CNT;
                            CMD_RUN:  state <= RUN;
                            CMD_STEP: state <= STEP;
                            default:  state <= IDLE; // Unknown byte ignored
                        endcase
                    end
                end
                LOAD_CNT: begin
                    if (i_rx_done) begin
                        word_cnt <= i_rx_data;
                        word_idx <= '0;
                        byte_idx <= '0;
                        state    <= (i_rx_data == 8'd0) ? ACK : LOAD_BYTE;
                    end
                end
                LOAD_BYTE: begin
                    if (i_rx_done) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            im_we    <= 1'b1; // Word lands in insn_buf this edge
                            im_addr  <= word_idx[IM_AW-1:0];
                            word_idx <= word_idx + 8'd1;
                            if (word_idx == word_cnt - 8'd1) state <= ACK;
                        end
                    end
                end
                RUN, STEP: begin
                    byte_idx <= '0;
                    word_idx <= '0;
                    if (i_hlt || state == STEP) state <= DUMP_PC;
                end
                ACK: begin
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= `DU_ACK_BYTE;
                        tx_busy    <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: begin
                    // Dump, one byte per transmitter slot
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= dump_word[8*byte_idx +: 8];
                        tx_busy    <= 1'b1;
                        byte_idx   <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            word_idx <= word_idx + 8'd1;
                            if (state == DUMP_PC) begin
                                word_idx <= '0;
                                state    <= DUMP_REG;
                            end else if (last_word) begin
                                word_idx <= '0;
                                state    <= (state == DUMP_REG) ? DUMP_DM : IDLE;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == LOAD_BYTE && i_rx_done) insn_buf <= {i_rx_data, insn_buf[31:8]};
    end

    always_comb begin
        o_dbg.im_we    = im_we;
        o_dbg.im_addr  = im_addr;
        o_dbg.im_wdata = insn_t'(insn_buf);
        o_dbg.exec_en  = (state == RUN || state == STEP) && !i_hlt;
        o_dbg.rd_addr  = word_idx[DBG_AW-1:0];
    end

    assign o_pc_clear = (state == ACK);
    assign o_state    = state;

endmodule

// ==== hw/du_cpu_pkg.sv ====
`include "du_cpu_params.svh"

package du_cpu_pkg;

    localparam int REG_AW = $clog2(`DU_NUM_REGS);
    localparam int DM_AW  = $clog2(`DU_DM_DEPTH);
    localparam int IM_AW  = $clog2(`DU_IM_DEPTH);
    localparam int DBG_AW = (REG_AW > DM_AW) ? REG_AW : DM_AW; // Shared reg/data index
    localparam int IMM_W  = 19;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_ADDI = 4'h3,
        OP_LW   = 4'h4,
        OP_SW   = 4'h5,
        OP_HALT = 4'hF
    } opcode_e;

    // Register form
    typedef struct packed {
        opcode_e                   opcode;
        logic [REG_AW-1:0]         rd;
        logic [REG_AW-1:0]         rs;
        logic [REG_AW-1:0]         rt;
        logic [32-4-3*REG_AW-1:0]  pad;
    } insn_r_t;

    // Immediate form, imm sits in the low bits
    typedef struct packed {
        opcode_e                        opcode;
        logic [REG_AW-1:0]              rd;
        logic [REG_AW-1:0]              rs;
        logic [32-4-2*REG_AW-IMM_W-1:0] rsvd;
        logic signed [IMM_W-1:0]        imm;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_t;

    typedef enum logic [7:0] {
        CMD_LOAD = 8'h4C, // L
        CMD_RUN  = 8'h52, // R
        CMD_STEP = 8'h53  // S
    } du_cmd_e;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        LOAD_CNT  = 4'd1,
        LOAD_BYTE = 4'd2,
        RUN       = 4'd3,
        STEP      = 4'd4,
        ACK       = 4'd5,
        DUMP_PC   = 4'd6,
        DUMP_REG  = 4'd7,
        DUMP_DM   = 4'd8
    } du_state_e;

    typedef struct packed {
        logic              im_we;
        logic [IM_AW-1:0]  im_addr;
        insn_t             im_wdata;
        logic              exec_en;
        logic [DBG_AW-1:0] rd_addr;
    } dbg_access_t;

endpackage

// ==== hw/du_cpu_top.sv ====
`timescale 1ns/1ns

module du_cpu_top import du_cpu_pkg::*; (
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_uart_rx,
    output logic       o_uart_tx,
    output logic       o_hlt,
    output logic [3:0] o_state
);

    logic [7:0]  rx_data;
    logic        rx_done;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic        tx_done;
    dbg_access_t dbg;
    logic        pc_clear;
    logic [31:0] pc;
    logic [31:0] reg_data;
    logic [31:0] dm_data;

    uart_core u_uart (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx       (i_uart_rx),
        .i_tx_data  (tx_data),
        .i_tx_start (tx_start),
        .o_rx_data  (rx_data),
        .o_rx_done  (rx_done),
        .o_tx       (o_uart_tx),
        .o_tx_done  (tx_done)
    );

    debug_unit u_debug (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .i_pc       (pc),
        .i_reg_data (reg_data),
        .i_dm_data  (dm_data),
        .i_hlt      (o_hlt),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .o_dbg      (dbg),
        .o_pc_clear (pc_clear),
        .o_state    (o_state)
    );

    data_path u_data_path (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_dbg      (dbg),
        .i_pc_clear (pc_clear),
        .o_pc       (pc),
        .o_reg_data (reg_data),
        .o_dm_data  (dm_data),
        .o_hlt      (o_hlt)
    );

endmodule

// ==== hw/uart_core.sv ====
`timescale 1ns/1ns
`include "du_cpu_params.svh"

module uart_core (
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_rx,
    input  logic [7:0] i_tx_data,
    input  logic       i_tx_start,
    output logic [7:0] o_rx_data,
    output logic       o_rx_done,
    output logic       o_tx,
    output logic       o_tx_done
);

    localparam int CPB  = `DU_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int CW   = $clog2(CPB);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e   rx_state;
    logic        rx_meta;
    logic        rx_sync;
    logic [CW-1:0] rx_cnt;
    logic [2:0]  rx_bit;
    logic        rx_sample; // Mid-bit strobe while shifting data

    logic        tx_busy;
    logic [9:0]  tx_frame;
    logic [CW-1:0] tx_cnt;
    logic [3:0]  tx_bit;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    assign rx_sample = (rx_state == RX_DATA) && (rx_cnt == CW'(CPB - 1));

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_state  <= RX_IDLE;
            rx_cnt    <= '0;
            rx_bit    <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync) rx_state <= RX_START;
                end
                RX_START: begin
                    if (rx_cnt == CW'(HALF - 1)) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync ? RX_IDLE : RX_DATA; // Glitch check
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (rx_sample) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) rx_state <= RX_STOP;
                    end
                end
                default: begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (rx_cnt == CW'(CPB - 1)) begin
                        rx_state  <= RX_IDLE;
                        o_rx_done <= rx_sync; // Bad stop bit drops the byte
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (rx_sample) o_rx_data <= {rx_sync, o_rx_data[7:1]}; // LSB first
    end

    // Idle frame is all ones so the line rests high
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tx_busy   <= 1'b0;
            tx_frame  <= '1;
            tx_cnt    <= '0;
            tx_bit    <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (!tx_busy) begin
                if (i_tx_start) begin
                    tx_busy  <= 1'b1;
                    tx_frame <= {1'b1, i_tx_data, 1'b0};
                    tx_cnt   <= '0;
                    tx_bit   <= '0;
                end
            end else if (tx_cnt == CW'(CPB - 1)) begin
                tx_cnt   <= '0;
                tx_frame <= {1'b1, tx_frame[9:1]};
                tx_bit   <= tx_bit + 4'd1;
                if (tx_bit == 4'd9) begin
                    tx_busy   <= 1'b0;
                    o_tx_done <= 1'b1;
                end
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

    assign o_tx = tx_frame[0];

endmodule

// ==== include/du_cpu_params.svh ====
`ifndef DU_CPU_PARAMS_SVH
`define DU_CPU_PARAMS_SVH

// Serial line
`define DU_CLKS_PER_BIT 8

// Memory and register bank sizes
`define DU_IM_DEPTH 32
`define DU_DM_DEPTH 8
`define DU_NUM_REGS 8

// Reply byte after a program load, ASCII K
`define DU_ACK_BYTE 8'h4B

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debug unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f du_cpu_top.f --top-module du_cpu_tb -o du_cpu_sim

if ./obj_dir/du_cpu_sim | tee /dev/stderr | grep -q "^TEST RESULT: PASS$"; then
    echo "Simulation finished without errors"
else
    echo "Simulation reported errors"
    exit 1
fi
